//--- verilog/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// Datapath widths
`define DIV_N_W 16
`define DIV_D_W 8
`define DIV_ROWS 8

// Approximation control
`define APPROX_ROWS_W 4
`define APPROX_ROWS_RST 6
`define APPROX_ROWS_MAX 8

// Register map
`define CFG_ADDR_W 2
`define CFG_DATA_W 16
`define CFG_WDATA_W 8
`define CFG_ADDR_APPROX 0
`define CFG_ADDR_DONE_CNT 1
`define CFG_ADDR_DZ_CNT 2
`define CFG_ADDR_OVF_CNT 3

`endif

//--- verilog/div_types_pkg.sv
`include "div_macros.svh"

package div_types_pkg;

  ////////////////////
  // Operands
  ////////////////////

  typedef logic [`DIV_N_W-1:0] dividend_t;   // Unsigned dividend
  typedef logic [`DIV_D_W-1:0] divisor_t;

  ////////////////////
  // Results
  ////////////////////

  typedef logic [`DIV_D_W-1:0] quot_t;
  typedef logic [`DIV_D_W-1:0] rem_t;        // Also a row's partial remainder

  // One bit per array row, set means approximate cells
  typedef logic [`DIV_ROWS-1:0] row_sel_t;

endpackage

//--- verilog/div_cfg_pkg.sv
`include "div_macros.svh"

package div_cfg_pkg;

  typedef logic [`CFG_ADDR_W-1:0]    cfg_addr_t;
  typedef logic [`CFG_DATA_W-1:0]    cfg_data_t;
  typedef logic [`APPROX_ROWS_W-1:0] approx_rows_t;   // 0 to 8

  // Pipeline occupancy
  typedef enum logic [1:0] {
    PIPE_IDLE,    // Nothing in flight
    PIPE_BUSY,    // Stage one holds an item
    PIPE_DRAIN    // Only the output stage holds an item
  } pipe_state_t;

endpackage

interface div_ctl_if import div_cfg_pkg::*; ();
  approx_rows_t approx_rows;
  logic         done;
  logic         div_zero;
  logic         overflow;

  modport cfg  (output approx_rows, input done, div_zero, overflow);
  modport pipe (input approx_rows, output done, div_zero, overflow);
endinterface

//--- verilog/div_array_row.sv
`include "div_macros.svh"

module div_array_row import div_types_pkg::*; (
  input  rem_t     minuend,
  input  divisor_t divisor,
  input  logic     approx,
  input  logic     top_bit,
  output logic     q_bit,
  output rem_t     rem_out
);

  logic [`DIV_D_W:0] borrow;
  rem_t              diff;

  assign borrow[0] = 1'b0;   // LSB cell has no borrow in

  ////////////////////
  // Subtractor cells
  ////////////////////

  for (genvar k = 0; k < `DIV_D_W; k++) begin : g_cell
    logic x;
    logic y;
    logic bin;
    logic bout_exact;
    logic bout_approx;

    assign x   = minuend[k];
    assign y   = divisor[k];
    assign bin = borrow[k];

    assign bout_exact  = (~x & y) | (~(x ^ y) & bin);
    assign bout_approx = (~x & (y | bin)) | (x & ~y & bin);   // Simplified borrow

    assign diff[k]     = approx ? x : (x ^ y ^ bin);   // Approx cell passes x
    assign borrow[k+1] = approx ? bout_approx : bout_exact;

    // Restore when the row does not subtract
    assign rem_out[k] = q_bit ? diff[k] : x;
  end

  assign q_bit = top_bit | ~borrow[`DIV_D_W];

endmodule

//--- verilog/div_array.sv
`include "div_macros.svh"

module div_array import div_types_pkg::*; (
  input  dividend_t n,
  input  divisor_t  d,
  input  row_sel_t  row_sel,
  output quot_t     q,
  output rem_t      r
);

  rem_t                 row_min [`DIV_ROWS];
  rem_t                 row_rem [`DIV_ROWS];
  logic [`DIV_ROWS-1:0] row_top;

  ////////////////////
  // Row chaining
  ////////////////////

  for (genvar j = 0; j < `DIV_ROWS; j++) begin : g_row
    if (j == `DIV_ROWS - 1) begin : g_first
      // Top row works on n[14:7], n[15] forces its quotient bit
      assign row_min[j] = n[`DIV_N_W-2 -: `DIV_D_W];
      assign row_top[j] = n[`DIV_N_W-1];
    end else begin : g_next
      // Shift in the next dividend bit under the previous remainder
      assign row_min[j] = {row_rem[j+1][`DIV_D_W-2:0], n[j]};
      assign row_top[j] = row_rem[j+1][`DIV_D_W-1];
    end

    div_array_row u_row (
      .minuend (row_min[j]),
      .divisor (d),
      .approx  (row_sel[j]),
      .top_bit (row_top[j]),
      .q_bit   (q[j]),
      .rem_out (row_rem[j])
    );
  end

  assign r = row_rem[0];   // Last row holds the remainder

endmodule

//--- verilog/div_cfg_regs.sv
`include "div_macros.svh"

module div_cfg_regs import div_cfg_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cfg_we,
  input  cfg_addr_t               cfg_addr,
  input  logic [`CFG_WDATA_W-1:0] cfg_wdata,
  output cfg_data_t               cfg_rdata,
  div_ctl_if.cfg                  ctl
);

  approx_rows_t approx_q;
  approx_rows_t wr_rows;
  logic         wr_approx;
  cfg_data_t    cnt [3];   // Done, div-by-zero, overflow
  logic [2:0]   cnt_inc;
  logic [2:0]   cnt_clr;

  ////////////////////
  // Approximation rows
  ////////////////////

  assign wr_approx = cfg_we && (cfg_addr == cfg_addr_t'(`CFG_ADDR_APPROX));
  assign wr_rows   = (cfg_wdata > `APPROX_ROWS_MAX) ? approx_rows_t'(`APPROX_ROWS_MAX)
                                                    : approx_rows_t'(cfg_wdata);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      approx_q <= approx_rows_t'(`APPROX_ROWS_RST);
    end else if (wr_approx) begin
      approx_q <= wr_rows;
    end
  end

  // Bypass so operands taken on the write edge see the new value
  assign ctl.approx_rows = wr_approx ? wr_rows : approx_q;

  ////////////////////
  // Event counters
  ////////////////////

  assign cnt_inc = {ctl.done & ctl.overflow, ctl.done & ctl.div_zero, ctl.done};

  assign cnt_clr[0] = cfg_we && (cfg_addr == cfg_addr_t'(`CFG_ADDR_DONE_CNT));
  assign cnt_clr[1] = cfg_we && (cfg_addr == cfg_addr_t'(`CFG_ADDR_DZ_CNT));
  assign cnt_clr[2] = cfg_we && (cfg_addr == cfg_addr_t'(`CFG_ADDR_OVF_CNT));

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (!rst_n || cnt_clr[i]) begin
        cnt[i] <= '0;
      end else if (cnt_inc[i]) begin
        cnt[i] <= cnt[i] + 1'b1;   // Wraps
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      cfg_addr_t'(`CFG_ADDR_APPROX):   cfg_rdata = cfg_data_t'(approx_q);
      cfg_addr_t'(`CFG_ADDR_DONE_CNT): cfg_rdata = cnt[0];
      cfg_addr_t'(`CFG_ADDR_DZ_CNT):   cfg_rdata = cnt[1];
      cfg_addr_t'(`CFG_ADDR_OVF_CNT):  cfg_rdata = cnt[2];
      default:                         cfg_rdata = '0;
    endcase
  end

  a_rows_max: assert property (@(posedge clk) disable iff (!rst_n)
    approx_q <= `APPROX_ROWS_MAX);

endmodule

//--- verilog/div_pipe.sv
`include "div_macros.svh"

module div_pipe import div_types_pkg::*, div_cfg_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  dividend_t n,
  input  divisor_t  d,
  div_ctl_if.pipe   ctl,
  output dividend_t arr_n,
  output divisor_t  arr_d,
  output row_sel_t  arr_sel,
  input  quot_t     arr_q,
  input  rem_t      arr_r,
  output logic      out_valid,
  output quot_t     q,
  output rem_t      r,
  output logic      div_zero,
  output logic      overflow
);

  pipe_state_t state;
  pipe_state_t state_nxt;
  row_sel_t    row_mask;
  dividend_t   s1_n;
  divisor_t    s1_d;
  row_sel_t    s1_sel;
  logic        s1_valid;
  logic        dz_s1;
  logic        ovf_s1;

  ////////////////////
  // Input stage
  ////////////////////

  // Thermometer mask, low rows go approximate first
  always_comb begin
    for (int j = 0; j < `DIV_ROWS; j++) begin
      row_mask[j] = (j < int'(ctl.approx_rows));
    end
  end

  always_comb begin
    state_nxt = PIPE_IDLE;
    if (in_valid) begin
      state_nxt = PIPE_BUSY;
    end else if (state == PIPE_BUSY) begin
      state_nxt = PIPE_DRAIN;   // Last item moves to output stage
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= PIPE_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign s1_valid = (state == PIPE_BUSY);

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_n   <= n;
      s1_d   <= d;
      s1_sel <= row_mask;   // Setting travels with the item
    end
  end

  assign arr_n   = s1_n;
  assign arr_d   = s1_d;
  assign arr_sel = s1_sel;

  ////////////////////
  // Output stage
  ////////////////////

  assign dz_s1  = (s1_d == '0);
  assign ovf_s1 = !dz_s1 && (s1_n[`DIV_N_W-1 -: `DIV_D_W] >= s1_d);   // Quotient won't fit

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      div_zero  <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      out_valid <= s1_valid;
      div_zero  <= s1_valid & dz_s1;
      overflow  <= s1_valid & ovf_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      q <= arr_q;
      r <= arr_r;
    end
  end

  assign ctl.done     = out_valid;
  assign ctl.div_zero = div_zero;
  assign ctl.overflow = overflow;

  // Stage one was loaded two edges back
  a_out_after_s1: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, 2));

endmodule

//--- verilog/approx_div_top.sv
`include "div_macros.svh"

module approx_div_top import div_types_pkg::*, div_cfg_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  // Operands
  input  logic                    in_valid,
  input  dividend_t               n,
  input  divisor_t                d,
  // Results
  output logic                    out_valid,
  output quot_t                   q,
  output rem_t                    r,
  output logic                    div_zero,
  output logic                    overflow,
  // Registers
  input  logic                    cfg_we,
  input  cfg_addr_t               cfg_addr,
  input  logic [`CFG_WDATA_W-1:0] cfg_wdata,
  output cfg_data_t               cfg_rdata
);

  dividend_t arr_n;
  divisor_t  arr_d;
  row_sel_t  arr_sel;
  quot_t     arr_q;
  rem_t      arr_r;

  div_ctl_if ctl0 ();

  div_pipe u_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .n         (n),
    .d         (d),
    .ctl       (ctl0.pipe),
    .arr_n     (arr_n),
    .arr_d     (arr_d),
    .arr_sel   (arr_sel),
    .arr_q     (arr_q),
    .arr_r     (arr_r),
    .out_valid (out_valid),
    .q         (q),
    .r         (r),
    .div_zero  (div_zero),
    .overflow  (overflow)
  );

  div_array u_array (
    .n       (arr_n),
    .d       (arr_d),
    .row_sel (arr_sel),
    .q       (arr_q),
    .r       (arr_r)
  );

  div_cfg_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .ctl       (ctl0.cfg)
  );

endmodule

//--- sim/tb_div_model.svh
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// Bit-level model of the restoring array, returns {q, r}
function automatic logic [15:0] div_model(input logic [15:0] nv, input logic [7:0] dv,
                                          input int rows);
  logic [7:0] minu;
  logic [7:0] rem;
  logic [7:0] diff;
  logic [7:0] qv;
  logic       top;
  logic       b;
  logic       x;
  logic       y;
  rem = 8'h00;
  qv  = 8'h00;
  for (int j = 7; j >= 0; j--) begin
    if (j == 7) begin
      minu = nv[14:7];
      top  = nv[15];
    end else begin
      minu = {rem[6:0], nv[j]};   // Next dividend bit under the remainder
      top  = rem[7];
    end
    b = 1'b0;
    for (int k = 0; k < 8; k++) begin
      x = minu[k];
      y = dv[k];
      if (j < rows) begin
        diff[k] = x;
        b       = (~x & (y | b)) | (x & ~y & b);
      end else begin
        diff[k] = x ^ y ^ b;
        b       = (~x & y) | (~(x ^ y) & b);
      end
    end
    qv[j] = top | ~b;
    rem   = qv[j] ? diff : minu;   // Restore on no subtract
  end
  return {qv, rem};
endfunction

`endif

//--- sim/tb_approx_div.sv
module tb_approx_div;

  localparam int N_TAB     = 17;
  localparam int N_RAND    = 40;
  localparam int N_REG_ACC = 17;   // Register accesses outside the table
  localparam int TIMEOUT   = N_TAB + N_RAND + N_REG_ACC + 20;

  typedef struct packed {
    logic        we;
    logic [1:0]  addr;
    logic [7:0]  wdata;
    logic        iv;
    logic [15:0] n;
    logic [7:0]  d;
    logic [3:0]  rows;    // Setting the item should see
    logic        chk;     // q and r given in the row
    logic [7:0]  q;
    logic [7:0]  r;
  } stim_t;

  typedef struct packed {
    logic [7:0] q;
    logic [7:0] r;
    logic       dz;
    logic       ovf;
    int         cyc;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic [15:0] n;
  logic [7:0]  d;
  logic        out_valid;
  logic [7:0]  q;
  logic [7:0]  r;
  logic        div_zero;
  logic        overflow;
  logic        cfg_we;
  logic [1:0]  cfg_addr;
  logic [7:0]  cfg_wdata;
  logic [15:0] cfg_rdata;

  stim_t tab [N_TAB];
  exp_t  exp_q [$];
  int    cyc = 0;
  int    seed;
  int    n_done = 0;
  int    n_dz = 0;
  int    n_ovf = 0;

  `include "tb_div_model.svh"

  approx_div_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .n         (n),
    .d         (d),
    .out_valid (out_valid),
    .q         (q),
    .r         (r),
    .div_zero  (div_zero),
    .overflow  (overflow),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT);
      stop_on_error();
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_on_error();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] expv);
    assert (got === expv) else begin
      $display("FAIL: %s got 0x%h expected 0x%h", name, got, expv);
      stop_on_error();
    end
  endtask

  function automatic stim_t op_row(input logic [15:0] nv, input logic [7:0] dv,
                                   input logic [3:0] rows, input logic chk,
                                   input logic [7:0] qv, input logic [7:0] rv);
    stim_t s;
    s      = '0;
    s.iv   = 1'b1;
    s.n    = nv;
    s.d    = dv;
    s.rows = rows;
    s.chk  = chk;
    s.q    = qv;
    s.r    = rv;
    return s;
  endfunction

  // Adds a write of the approximation register to a row
  function automatic stim_t set_rows(input stim_t s, input logic [7:0] w);
    stim_t t;
    t       = s;
    t.we    = 1'b1;
    t.addr  = 2'd0;
    t.wdata = w;
    return t;
  endfunction

  task automatic load_table();
    tab[0]  = set_rows(stim_t'(0), 8'd0);   // Exact mode
    tab[1]  = op_row(16'h03E8, 8'h07, 4'd0, 1'b1, 8'h8E, 8'h06);
    tab[2]  = op_row(16'h1234, 8'h50, 4'd0, 1'b1, 8'h3A, 8'h14);
    tab[3]  = op_row(16'hFEFF, 8'hFF, 4'd0, 1'b1, 8'hFF, 8'hFE);
    tab[4]  = op_row(16'h0000, 8'h01, 4'd0, 1'b1, 8'h00, 8'h00);
    tab[5]  = op_row(16'h00FF, 8'h10, 4'd0, 1'b1, 8'h0F, 8'h0F);
    tab[6]  = op_row(16'h7FFF, 8'h80, 4'd0, 1'b1, 8'hFF, 8'h7F);
    tab[7]  = op_row(16'h0C35, 8'h0D, 4'd0, 1'b1, 8'hF0, 8'h05);
    tab[8]  = op_row(16'h1234, 8'h00, 4'd0, 1'b0, 8'h00, 8'h00);   // Divide by zero
    tab[9]  = op_row(16'h9000, 8'h20, 4'd0, 1'b0, 8'h00, 8'h00);   // Overflow
    // Setting changes on the cycle of the next item
    tab[10] = set_rows(op_row(16'h2345, 8'h3C, 4'd6, 1'b0, 8'h00, 8'h00), 8'd6);
    tab[11] = set_rows(op_row(16'h2345, 8'h3C, 4'd8, 1'b0, 8'h00, 8'h00), 8'd8);
    tab[12] = op_row(16'h0C35, 8'h0D, 4'd8, 1'b0, 8'h00, 8'h00);
    tab[13] = set_rows(op_row(16'h7FFF, 8'h80, 4'd8, 1'b0, 8'h00, 8'h00), 8'd12);
    tab[14] = stim_t'(0);
    tab[15] = set_rows(stim_t'(0), 8'd6);
    tab[16] = op_row(16'h1234, 8'h50, 4'd6, 1'b0, 8'h00, 8'h00);
  endtask

  task automatic apply(input stim_t s);
    exp_t        e;
    logic [15:0] res;
    @(negedge clk);
    cfg_we    = s.we;
    cfg_addr  = s.addr;
    cfg_wdata = s.wdata;
    in_valid  = s.iv;
    n         = s.n;
    d         = s.d;
    if (s.iv) begin
      res   = div_model(s.n, s.d, int'(s.rows));
      e.q   = s.chk ? s.q : res[15:8];
      e.r   = s.chk ? s.r : res[7:0];
      e.dz  = (s.d == 8'h00);
      e.ovf = (s.d != 8'h00) && (s.n[15:8] >= s.d);
      e.cyc = cyc;
      exp_q.push_back(e);
      n_done = n_done + 1;
      n_dz   = n_dz + int'(e.dz);
      n_ovf  = n_ovf + int'(e.ovf);
    end
  endtask

  task automatic read_reg(input logic [1:0] addr, input logic [15:0] expv);
    @(negedge clk);
    cfg_we   = 1'b0;
    in_valid = 1'b0;
    cfg_addr = addr;
    #1;
    check_val("cfg_rdata", cfg_rdata, expv);
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    @(negedge clk);
    in_valid  = 1'b0;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
  endtask

  ////////////////////
  // Result checking
  ////////////////////

  always @(negedge clk) begin : result_check
    exp_t e;
    if (rst_n && out_valid) begin
      assert (exp_q.size() > 0) else begin
        $display("ERROR: out_valid went high with no result pending");
        stop_on_error();
      end
      e = exp_q.pop_front();
      assert (cyc == e.cyc + 2) else begin
        $display("ERROR: result arrived %0d cycles after its input instead of 2", cyc - e.cyc);
        stop_on_error();
      end
      check_val("q", 16'(q), 16'(e.q));
      check_val("r", 16'(r), 16'(e.r));
      check_val("div_zero", 16'(div_zero), 16'(e.dz));
      check_val("overflow", 16'(overflow), 16'(e.ovf));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    stim_t       s;
    logic [15:0] rn;
    logic [7:0]  rd;
    logic [3:0]  rows;
    seed      = 32'h15934404;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    n         = 16'h0000;
    d         = 8'h00;
    cfg_we    = 1'b0;
    cfg_addr  = 2'd0;
    cfg_wdata = 8'h00;
    load_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_val("out_valid", 16'(out_valid), 16'h0000);
    check_val("div_zero", 16'(div_zero), 16'h0000);
    check_val("overflow", 16'(overflow), 16'h0000);
    read_reg(2'd0, 16'h0006);
    read_reg(2'd1, 16'h0000);
    read_reg(2'd2, 16'h0000);
    read_reg(2'd3, 16'h0000);

    for (int i = 0; i < N_TAB; i++) begin
      apply(tab[i]);
    end

    for (int i = 0; i < N_RAND; i++) begin
      rn = 16'($random(seed));
      rd = 8'($random(seed));
      if (i[0]) begin
        rn    = rn >> 1;
        rd[7] = 1'b1;   // Keeps n[15:8] below d
      end
      rows = (i < N_RAND / 2) ? 4'd6 : 4'd8;
      s    = op_row(rn, rd, rows, 1'b0, 8'h00, 8'h00);
      if (i == 0 || i == N_RAND / 2) begin
        s = set_rows(s, 8'(rows));
      end
      apply(s);
    end
    apply(stim_t'(0));
    while (exp_q.size() > 0) @(negedge clk);

    read_reg(2'd1, 16'(n_done));
    read_reg(2'd2, 16'(n_dz));
    read_reg(2'd3, 16'(n_ovf));
    write_reg(2'd1, 8'h00);
    read_reg(2'd1, 16'h0000);
    read_reg(2'd3, 16'(n_ovf));   // Only the addressed counter clears
    write_reg(2'd3, 8'h00);
    read_reg(2'd3, 16'h0000);
    read_reg(2'd2, 16'(n_dz));
    write_reg(2'd2, 8'h00);
    read_reg(2'd2, 16'h0000);
    write_reg(2'd0, 8'd12);
    read_reg(2'd0, 16'h0008);   // Saturated
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- approx_div_top.f
+incdir+verilog
+incdir+sim
verilog/div_types_pkg.sv
verilog/div_cfg_pkg.sv
verilog/div_array_row.sv
verilog/div_array.sv
verilog/div_cfg_regs.sv
verilog/div_pipe.sv
verilog/approx_div_top.sv
sim/tb_approx_div.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the approximate divider testbench

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_approx_div -f approx_div_top.f \
  --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
